//--- include/perf_defs.svh
`ifndef PERF_DEFS_SVH
`define PERF_DEFS_SVH

// counter and report sizes
`define PERF_CNT_W	12
`define PERF_NUM_EVT	8
`define PERF_RPT_LEN	21

// configuration registers
`define PERF_CFG_W	16
`define PERF_BAUD_RST	16'd868	// clocks per bit
`define PERF_GAP_RST	16'd1000	// idle clocks before each char

`endif

//--- hw/perf_pkg.sv
`default_nettype none
`include "perf_defs.svh"

package perf_pkg;

	// bit positions on the event vector
	typedef enum logic [2:0] {
		EVT_L1I_READ  = 3'd0,
		EVT_L1I_MISS  = 3'd1,
		EVT_L1D_READ  = 3'd2,
		EVT_L1D_WRITE = 3'd3,
		EVT_L1D_MISS  = 3'd4,
		EVT_L2_READ   = 3'd5,
		EVT_L2_WRITE  = 3'd6,
		EVT_L2_MISS   = 3'd7
	} evt_e;

	typedef logic [`PERF_CNT_W-1:0] cnt_t;

	typedef cnt_t [`PERF_NUM_EVT-1:0] cnt_vec_t;	// indexed by evt_e

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,	// snap strobe, counts latched
		ST_GAP,
		ST_SEND	// tx_start strobe
	} seq_state_e;

endpackage

`default_nettype wire

//--- hw/event_counter.sv
`default_nettype none
`timescale 1ns/100ps
`include "perf_defs.svh"

module event_counter (
	input wire clk,
	input wire rstn,
	input wire [`PERF_NUM_EVT-1:0] evt_i,
	input wire snap_i,
	output logic [`PERF_NUM_EVT-1:0][`PERF_CNT_W-1:0] cnt_o
);

	logic [`PERF_NUM_EVT-1:0] evt_q;	// previous sample
	logic [`PERF_NUM_EVT-1:0] rise;
	perf_pkg::cnt_vec_t cnt_q;
	perf_pkg::cnt_vec_t cnt_d;

	assign rise = evt_i & ~evt_q;
	assign cnt_o = cnt_q;

	for (genvar i = 0; i < `PERF_NUM_EVT; i++) begin : g_evt
		localparam perf_pkg::evt_e EVT = perf_pkg::evt_e'(i);

		// an edge in the snap cycle already belongs to the new interval
		assign cnt_d[EVT] = snap_i ? perf_pkg::cnt_t'(rise[EVT]) :
			cnt_q[EVT] + perf_pkg::cnt_t'(rise[EVT]);	// wraps at 4096

		a_step: assert property (@(posedge clk) disable iff (!rstn)
			!snap_i |=> (cnt_q[EVT] == $past(cnt_q[EVT])) ||
				(cnt_q[EVT] == perf_pkg::cnt_t'($past(cnt_q[EVT]) + 1'b1)));
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			evt_q <= '0;
			cnt_q <= '0;
		end else begin
			evt_q <= evt_i;
			cnt_q <= cnt_d;
		end
	end

endmodule

`default_nettype wire

//--- hw/perf_cfg_regs.sv
`default_nettype none
`timescale 1ns/100ps
`include "perf_defs.svh"

module perf_cfg_regs (
	input wire clk,
	input wire rstn,
	input wire cfg_we_i,
	input wire cfg_addr_i,
	input wire [`PERF_CFG_W-1:0] cfg_wdata_i,
	output logic [`PERF_CFG_W-1:0] cfg_rdata_o,
	output logic [`PERF_CFG_W-1:0] baud_div_o,
	output logic [`PERF_CFG_W-1:0] char_gap_o
);

	localparam logic [`PERF_CFG_W-1:0] BAUD_MIN = 4;

	logic [`PERF_CFG_W-1:0] baud_q;	// addr 0
	logic [`PERF_CFG_W-1:0] gap_q;	// addr 1
	logic [`PERF_CFG_W-1:0] baud_wr;

	// shorter bit periods leave the tx counter no room
	assign baud_wr = (cfg_wdata_i < BAUD_MIN) ? BAUD_MIN : cfg_wdata_i;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			baud_q <= `PERF_BAUD_RST;
			gap_q <= `PERF_GAP_RST;
		end else if (cfg_we_i) begin
			if (cfg_addr_i) begin
				gap_q <= cfg_wdata_i;
			end else begin
				baud_q <= baud_wr;
			end
		end
	end

	assign cfg_rdata_o = cfg_addr_i ? gap_q : baud_q;
	assign baud_div_o = baud_q;
	assign char_gap_o = gap_q;

	a_baud_min: assert property (@(posedge clk) disable iff (!rstn)
		baud_div_o >= BAUD_MIN);

endmodule

`default_nettype wire

//--- hw/report_sequencer.sv
`default_nettype none
`timescale 1ns/100ps
`include "perf_defs.svh"

module report_sequencer (
	input wire clk,
	input wire rstn,
	input wire cpu_done_i,
	input wire [`PERF_NUM_EVT-1:0][`PERF_CNT_W-1:0] cnt_i,
	input wire [`PERF_CFG_W-1:0] char_gap_i,
	input wire tx_busy_i,
	output logic snap_o,
	output logic tx_start_o,
	output logic [7:0] tx_data_o,
	output logic done_o
);

	localparam logic [4:0] LAST = 5'(`PERF_RPT_LEN - 1);

	perf_pkg::seq_state_e state_q;
	logic done_prev_q;
	logic [4:0] idx_q;	// char index 0..20
	logic last_q;	// final char handed to tx
	logic [`PERF_CFG_W-1:0] gap_q;
	perf_pkg::cnt_vec_t snap_q;
	logic [1:0] grp;	// a, b, c
	logic [4:0] grp_base;
	logic [2:0] pos;	// 0 marker, 1..3 miss, 4..6 access
	perf_pkg::cnt_t val;
	logic [3:0] nib;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state_q <= perf_pkg::ST_IDLE;
			done_prev_q <= 1'b0;
			idx_q <= '0;
			last_q <= 1'b0;
			gap_q <= '0;
		end else begin
			done_prev_q <= cpu_done_i;
			case (state_q)
				perf_pkg::ST_IDLE: begin
					if (cpu_done_i && !done_prev_q) begin
						state_q <= perf_pkg::ST_LOAD;
					end
				end
				perf_pkg::ST_LOAD: begin
					state_q <= perf_pkg::ST_GAP;
					idx_q <= '0;
					last_q <= 1'b0;
					gap_q <= char_gap_i;
				end
				perf_pkg::ST_GAP: begin
					if (tx_busy_i) begin
						gap_q <= char_gap_i;	// restart gap until busy falls
					end else if (last_q) begin
						state_q <= perf_pkg::ST_IDLE;
					end else if (gap_q[`PERF_CFG_W-1:1] == '0) begin
						state_q <= perf_pkg::ST_SEND;	// gap at 0 or 1
					end else begin
						gap_q <= gap_q - 1'b1;
					end
				end
				default: begin
					state_q <= perf_pkg::ST_GAP;
					if (idx_q == LAST) begin
						last_q <= 1'b1;
					end else begin
						idx_q <= idx_q + 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == perf_pkg::ST_LOAD) begin
			snap_q <= cnt_i;
		end
	end

	always_comb begin
		if (idx_q >= 5'd14) begin
			grp = 2'd2;
			grp_base = 5'd14;
		end else if (idx_q >= 5'd7) begin
			grp = 2'd1;
			grp_base = 5'd7;
		end else begin
			grp = 2'd0;
			grp_base = 5'd0;
		end
	end

	assign pos = 3'(idx_q - grp_base);

	// access sums wrap to 12 bits
	always_comb begin
		case (grp)
			2'd0: val = (pos < 3'd4) ? snap_q[perf_pkg::EVT_L1I_MISS] :
				snap_q[perf_pkg::EVT_L1I_READ];
			2'd1: val = (pos < 3'd4) ? snap_q[perf_pkg::EVT_L1D_MISS] :
				snap_q[perf_pkg::EVT_L1D_READ] + snap_q[perf_pkg::EVT_L1D_WRITE];
			default: val = (pos < 3'd4) ? snap_q[perf_pkg::EVT_L2_MISS] :
				snap_q[perf_pkg::EVT_L2_READ] + snap_q[perf_pkg::EVT_L2_WRITE];
		endcase
	end

	always_comb begin
		case (pos)
			3'd1, 3'd4: nib = val[11:8];
			3'd2, 3'd5: nib = val[7:4];
			default: nib = val[3:0];
		endcase
	end

	always_comb begin
		if (pos == 3'd0) begin
			tx_data_o = 8'h61 + {6'd0, grp};	// 'a' + group
		end else if (nib < 4'd10) begin
			tx_data_o = 8'h30 + {4'd0, nib};
		end else begin
			tx_data_o = 8'h37 + {4'd0, nib};	// 'A'..'F'
		end
	end

	assign snap_o = (state_q == perf_pkg::ST_LOAD);
	assign tx_start_o = (state_q == perf_pkg::ST_SEND);
	assign done_o = (state_q != perf_pkg::ST_IDLE);

	a_start_idle: assert property (@(posedge clk) disable iff (!rstn)
		tx_start_o |-> !tx_busy_i);

	a_idx_range: assert property (@(posedge clk) disable iff (!rstn)
		idx_q < 5'(`PERF_RPT_LEN));

endmodule

`default_nettype wire

//--- hw/uart_tx.sv
`default_nettype none
`timescale 1ns/100ps
`include "perf_defs.svh"

module uart_tx (
	input wire clk,
	input wire rstn,
	input wire tx_start_i,
	input wire [7:0] tx_data_i,
	input wire [`PERF_CFG_W-1:0] baud_div_i,
	output logic tx_o,
	output logic tx_busy_o
);

	logic [9:0] frame_q;	// stop, data, start; bit 0 on the line
	logic [`PERF_CFG_W-1:0] div_q;	// bit period taken at start
	logic [`PERF_CFG_W-1:0] tick_q;
	logic [3:0] bit_q;
	logic busy_q;
	logic bit_end;

	assign bit_end = (tick_q == div_q - 1'b1);

	always_ff @(posedge clk) begin
		if (!tx_busy_o && tx_start_i) begin
			div_q <= baud_div_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			frame_q <= '1;	// idle high
			busy_q <= 1'b0;
			tick_q <= '0;
			bit_q <= '0;
		end else if (!busy_q) begin
			if (tx_start_i) begin
				frame_q <= {1'b1, tx_data_i, 1'b0};
				busy_q <= 1'b1;
				tick_q <= '0;
				bit_q <= '0;
			end
		end else if (bit_end) begin
			tick_q <= '0;
			frame_q <= {1'b1, frame_q[9:1]};	// lsb first, refill with idle
			if (bit_q == 4'd9) begin
				busy_q <= 1'b0;
			end else begin
				bit_q <= bit_q + 1'b1;
			end
		end else begin
			tick_q <= tick_q + 1'b1;
		end
	end

	assign tx_o = frame_q[0];
	assign tx_busy_o = busy_q;

endmodule

`default_nettype wire

//--- hw/cache_perf_top.sv
`default_nettype none
`timescale 1ns/100ps
`include "perf_defs.svh"

module cache_perf_top (
	input wire clk,
	input wire rstn,
	input wire read_l1i_i,
	input wire miss_l1i_i,
	input wire read_l1d_i,
	input wire write_l1d_i,
	input wire miss_l1d_i,
	input wire read_l2_i,
	input wire write_l2_i,
	input wire miss_l2_i,
	input wire cpu_done_i,
	input wire cfg_we_i,
	input wire cfg_addr_i,
	input wire [`PERF_CFG_W-1:0] cfg_wdata_i,
	output wire [`PERF_CFG_W-1:0] cfg_rdata_o,
	output wire tx_o,
	output wire done_o
);

	logic [`PERF_NUM_EVT-1:0] evt;
	perf_pkg::cnt_vec_t cnt_vec;
	logic snap;
	logic [`PERF_CFG_W-1:0] baud_div;
	logic [`PERF_CFG_W-1:0] char_gap;
	logic tx_start;
	logic [7:0] tx_data;
	logic tx_busy;

	assign evt[perf_pkg::EVT_L1I_READ] = read_l1i_i;
	assign evt[perf_pkg::EVT_L1I_MISS] = miss_l1i_i;
	assign evt[perf_pkg::EVT_L1D_READ] = read_l1d_i;
	assign evt[perf_pkg::EVT_L1D_WRITE] = write_l1d_i;
	assign evt[perf_pkg::EVT_L1D_MISS] = miss_l1d_i;
	assign evt[perf_pkg::EVT_L2_READ] = read_l2_i;
	assign evt[perf_pkg::EVT_L2_WRITE] = write_l2_i;
	assign evt[perf_pkg::EVT_L2_MISS] = miss_l2_i;

	event_counter i_event_counter (
		.clk    (clk),
		.rstn   (rstn),
		.evt_i  (evt),
		.snap_i (snap),
		.cnt_o  (cnt_vec)
	);

	perf_cfg_regs i_perf_cfg_regs (
		.clk         (clk),
		.rstn        (rstn),
		.cfg_we_i    (cfg_we_i),
		.cfg_addr_i  (cfg_addr_i),
		.cfg_wdata_i (cfg_wdata_i),
		.cfg_rdata_o (cfg_rdata_o),
		.baud_div_o  (baud_div),
		.char_gap_o  (char_gap)
	);

	report_sequencer i_report_sequencer (
		.clk        (clk),
		.rstn       (rstn),
		.cpu_done_i (cpu_done_i),
		.cnt_i      (cnt_vec),
		.char_gap_i (char_gap),
		.tx_busy_i  (tx_busy),
		.snap_o     (snap),
		.tx_start_o (tx_start),
		.tx_data_o  (tx_data),
		.done_o     (done_o)
	);

	uart_tx i_uart_tx (
		.clk        (clk),
		.rstn       (rstn),
		.tx_start_i (tx_start),
		.tx_data_i  (tx_data),
		.baud_div_i (baud_div),
		.tx_o       (tx_o),
		.tx_busy_o  (tx_busy)
	);

endmodule

`default_nettype wire

//--- testbench/tb_cache_perf.sv
`default_nettype none
`timescale 1ns/100ps
`include "perf_defs.svh"

module tb_cache_perf;

	localparam int RST_CYCLES = 4;
	localparam int PULSE_LIMIT = 40000;

	logic clk;
	logic rstn;
	logic [`PERF_NUM_EVT-1:0] evt;
	logic cpu_done;
	logic cfg_we;
	logic cfg_addr;
	logic [`PERF_CFG_W-1:0] cfg_wdata;
	wire [`PERF_CFG_W-1:0] cfg_rdata;
	wire tx;
	wire done;

	int cyc;	// rising edges so far
	int bit_per;
	int gap;
	int retrig;
	int pulses [`PERF_NUM_EVT];
	logic [8*`PERF_RPT_LEN-1:0] exp_chars;	// first char in top byte
	int stop_end;	// edge where the last stop bit ended

	cache_perf_top i_cache_perf_top (
		.clk         (clk),
		.rstn        (rstn),
		.read_l1i_i  (evt[perf_pkg::EVT_L1I_READ]),
		.miss_l1i_i  (evt[perf_pkg::EVT_L1I_MISS]),
		.read_l1d_i  (evt[perf_pkg::EVT_L1D_READ]),
		.write_l1d_i (evt[perf_pkg::EVT_L1D_WRITE]),
		.miss_l1d_i  (evt[perf_pkg::EVT_L1D_MISS]),
		.read_l2_i   (evt[perf_pkg::EVT_L2_READ]),
		.write_l2_i  (evt[perf_pkg::EVT_L2_WRITE]),
		.miss_l2_i   (evt[perf_pkg::EVT_L2_MISS]),
		.cpu_done_i  (cpu_done),
		.cfg_we_i    (cfg_we),
		.cfg_addr_i  (cfg_addr),
		.cfg_wdata_i (cfg_wdata),
		.cfg_rdata_o (cfg_rdata),
		.tx_o        (tx),
		.done_o      (done)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic next_cycle;
		@(posedge clk);
		#2;	// drive and sample point
		cyc++;
	endtask

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
		end
	endtask

	task automatic write_cfg(input logic addr, input logic [`PERF_CFG_W-1:0] data);
		cfg_we = 1'b1;
		cfg_addr = addr;
		cfg_wdata = data;
		next_cycle();
		cfg_we = 1'b0;
	endtask

	task automatic read_cfg(input logic addr, output logic [`PERF_CFG_W-1:0] data);
		cfg_addr = addr;
		next_cycle();
		data = cfg_rdata;
	endtask

	task automatic wait_done(input logic want, input int limit, input string what);
		int n;
		n = 0;
		while (done !== want) begin
			if (n >= limit) begin
				fail_run(what);
			end
			next_cycle();
			n++;
		end
	endtask

	// one-cycle pulses with random spacing until every count is used up
	task automatic drive_events;
		int n;
		logic active;
		n = 0;
		active = 1'b1;
		while (active) begin
			if (n >= PULSE_LIMIT) begin
				fail_run("event pulses did not finish within the cycle limit");
			end
			active = 1'b0;
			for (int e = 0; e < `PERF_NUM_EVT; e++) begin
				if (evt[e]) begin
					evt[e] = 1'b0;
				end else if (pulses[e] > 0 && ($urandom % 3) != 0) begin
					evt[e] = 1'b1;
					pulses[e]--;
				end
				if (pulses[e] > 0 || evt[e]) begin
					active = 1'b1;
				end
			end
			next_cycle();
			n++;
		end
	endtask

	task automatic receive_char(input int idx, output logic [7:0] ch);
		int n;
		int start;
		int idle;
		ch = '0;
		n = 0;
		while (tx !== 1'b0) begin
			if (n >= gap + 4 * bit_per + 64) begin
				fail_run($sformatf("no start bit seen for character %0d", idx));
			end
			check_value("done_o", 32'(done), 32'd1);
			if (retrig != 0) begin
				cpu_done = ~cpu_done;	// must not restart the report
			end
			next_cycle();
			n++;
		end
		start = cyc;
		idle = start - stop_end;
		if (idx > 0 && idle < gap) begin
			fail_run($sformatf("character %0d began %0d cycles after the stop bit, gap is %0d",
				idx, idle, gap));
		end
		for (int b = 0; b < 10; b++) begin
			while (cyc < start + b * bit_per + bit_per / 2) begin
				check_value("done_o", 32'(done), 32'd1);
				next_cycle();
			end
			if (b == 0) begin
				check_value("tx_o start bit", 32'(tx), 32'd0);
			end else if (b == 9) begin
				check_value("tx_o stop bit", 32'(tx), 32'd1);
			end else begin
				ch[b-1] = tx;	// lsb first
			end
		end
		stop_end = start + 10 * bit_per;
	endtask

	task automatic run_case(input int idx);
		logic [`PERF_CFG_W-1:0] rd;
		logic [`PERF_CFG_W-1:0] want_baud;
		logic [7:0] ch;
		want_baud = (bit_per < 4) ? 16'd4 : 16'(bit_per);
		write_cfg(1'b0, 16'(bit_per));
		write_cfg(1'b1, 16'(gap));
		read_cfg(1'b0, rd);
		check_value("cfg_rdata_o baud", 32'(rd), 32'(want_baud));
		read_cfg(1'b1, rd);
		check_value("cfg_rdata_o gap", 32'(rd), 32'(gap));
		bit_per = int'(want_baud);
		drive_events();
		repeat (2) next_cycle();
		cpu_done = 1'b1;
		wait_done(1'b1, 4, $sformatf("done_o did not rise in case %0d", idx));
		for (int i = 0; i < `PERF_RPT_LEN; i++) begin
			receive_char(i, ch);
			check_value($sformatf("tx_o case %0d char %0d", idx, i), 32'(ch),
				32'(exp_chars[8*(`PERF_RPT_LEN-1-i) +: 8]));
		end
		wait_done(1'b0, bit_per + 8, $sformatf("done_o did not fall in case %0d", idx));
		check_value("done_o fall cycle", cyc, stop_end + 1);
		cpu_done = 1'b0;
		repeat (gap + 12 * bit_per) begin
			next_cycle();
			check_value("tx_o idle", 32'(tx), 32'd1);	// no extra char
			check_value("done_o idle", 32'(done), 32'd0);
		end
	endtask

	initial begin
		int fd;
		int rc;
		int n_cases;
		string line;
		logic [`PERF_CFG_W-1:0] rd;
		void'($urandom(32'h97e0_8cd8));
		rstn = 1'b0;
		evt = '0;
		cpu_done = 1'b0;
		cfg_we = 1'b0;
		cfg_addr = 1'b0;
		cfg_wdata = '0;
		cyc = 0;
		stop_end = 0;
		repeat (RST_CYCLES) next_cycle();
		rstn = 1'b1;
		next_cycle();
		check_value("tx_o", 32'(tx), 32'd1);
		check_value("done_o", 32'(done), 32'd0);
		read_cfg(1'b0, rd);
		check_value("cfg_rdata_o baud", 32'(rd), 32'(`PERF_BAUD_RST));
		read_cfg(1'b1, rd);
		check_value("cfg_rdata_o gap", 32'(rd), 32'(`PERF_GAP_RST));

		fd = $fopen("testbench/perf_cases.txt", "r");
		if (fd == 0) begin
			fail_run("cannot open testbench/perf_cases.txt");
		end
		n_cases = 0;
		while (!$feof(fd)) begin
			line = "";
			rc = $fgets(line, fd);
			if (rc <= 1 || line.getc(0) == "#") begin
				continue;
			end
			rc = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %h", bit_per, gap, retrig,
				pulses[0], pulses[1], pulses[2], pulses[3], pulses[4], pulses[5],
				pulses[6], pulses[7], exp_chars);
			if (rc != 12) begin
				fail_run($sformatf("malformed line in case file: %s", line));
			end
			run_case(n_cases);
			n_cases++;
		end
		$fclose(fd);
		if (n_cases == 0) begin
			fail_run("no cases found in testbench/perf_cases.txt");
		end else begin
			$display("TEST OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- testbench/perf_cases.txt
# bit_period gap retrig l1i_rd l1i_miss l1d_rd l1d_wr l1d_miss l2_rd l2_wr l2_miss
# then the 21 report characters as one hex string, first character leftmost
4 3 0 5 2 7 3 1 4 2 1 613030323030356230303130304163303031303036
2 0 0 0 0 0 0 0 0 0 0 613030303030306230303030303063303030303030
5 2 0 0 0 4100 10 3 0 0 0 613030303030306230303330304563303030303030
6 5 1 171 12 20 30 15 9 6 13 613030433041426230304630333263303044303046
8 12 0 300 44 100 100 60 20 25 30 613032433132436230334330433863303145303244
4 1 1 0 7 0 9 0 0 11 5 613030373030306230303030303963303035303042
10 40 0 255 0 0 0 0 255 255 0 613030303046466230303030303063303030314645
4 3 1 1 1 1 1 1 1 1 1 613030313030316230303130303263303031303032

//--- build.f
+incdir+include
hw/perf_pkg.sv
hw/event_counter.sv
hw/perf_cfg_regs.sv
hw/report_sequencer.sv
hw/uart_tx.sv
hw/cache_perf_top.sv
testbench/tb_cache_perf.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cache_perf
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= TEST FAILED
PASS_MSG  ?= TEST OK

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(FILELIST) $(wildcard include/*.svh hw/*.sv testbench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
